// File: include/tcb_lite_map.svh
// address map macros: memory windows, register window, window spans
`ifndef TCB_LITE_MAP_SVH
`define TCB_LITE_MAP_SVH

// memory 0 window, first 1 KiB
`define MAP_MEM0_BASE 32'h0000_0000

// memory 1 window, directly above memory 0
`define MAP_MEM1_BASE 32'h0000_0400

// control register window
`define MAP_REGS_BASE 32'h0000_1000

// byte span of each memory window
`define MAP_MEM_SPAN 32'h0000_0400

// byte span of the register window
`define MAP_REGS_SPAN 32'h0000_0010

`endif

// File: hdl/tcb_lite_pkg.sv
// bus package: data types, request/response structs, register offsets, identity value
package tcb_lite_pkg;

    ////////////////////
    // basic bus types
    ////////////////////

    // byte address
    typedef logic [31:0] adr_t;
    // data word, read or write
    typedef logic [31:0] dat_t;
    // byte enables, one per lane
    typedef logic [3:0]  byt_t;
    // log2 of transfer byte count
    typedef logic [1:0]  siz_t;

    ////////////////////
    // request / response
    ////////////////////

    // manager to subordinate
    typedef struct packed {
        logic vld;
        logic lck;
        logic wen;
        adr_t adr;
        siz_t siz;
        byt_t byt;
        dat_t wdt;
    } tcb_req_t;

    // subordinate to manager
    // rdy is combinational, rdt/err one cycle after the transfer
    typedef struct packed {
        dat_t rdt;
        logic err;
        logic rdy;
    } tcb_rsp_t;

    ////////////////////
    // register block
    ////////////////////

    // byte offsets inside the register window
    localparam adr_t REG_SCRATCH = 32'h0000_0000;
    localparam adr_t REG_ID      = 32'h0000_0004;
    localparam adr_t REG_WCOUNT  = 32'h0000_0008;

    // read-only identity word
    localparam dat_t REG_ID_VALUE = 32'h7CB1_0001;

endpackage: tcb_lite_pkg

// File: hdl/tcb_lite_decoder.sv
// address decoder: request address to subordinate select index
`timescale 1ns/1ps
`include "tcb_lite_map.svh"

module tcb_lite_decoder (
    // request address
    input  tcb_lite_pkg::adr_t adr,
    // subordinate select
    output logic [1:0]         sel
);

    import tcb_lite_pkg::*;

    ////////////////////
    // window constants
    ////////////////////

    // keeps the bits above the memory window offset
    localparam adr_t MEM_MASK = ~(`MAP_MEM_SPAN - 32'd1);

    // select encoding
    localparam logic [1:0] SEL_MEM0 = 2'd0;
    localparam logic [1:0] SEL_MEM1 = 2'd1;
    localparam logic [1:0] SEL_REGS = 2'd2;

    ////////////////////
    // decode
    ////////////////////

    // memories first, everything else to the register block
    // unmapped addresses get an error from there
    always_comb begin
        if ((adr & MEM_MASK) == `MAP_MEM0_BASE) begin
            sel = SEL_MEM0;
        end else if ((adr & MEM_MASK) == `MAP_MEM1_BASE) begin
            sel = SEL_MEM1;
        end else begin
            sel = SEL_REGS;
        end
    end

endmodule: tcb_lite_decoder

// File: hdl/tcb_lite_demultiplexer.sv
// bus demultiplexer: request steering, rdy return, registered response select
`timescale 1ns/1ps

module tcb_lite_demultiplexer #(
    // number of subordinate ports
    parameter  int unsigned IFN = 3,
    // select width
    localparam int unsigned IFL = $clog2(IFN)
)(
    // clock and reset
    input  logic                   sub,
    input  logic                   rst_n,
    // port select from the decoder
    input  logic [IFL-1:0]         sel,
    // manager side
    input  tcb_lite_pkg::tcb_req_t req,
    output tcb_lite_pkg::tcb_rsp_t rsp,
    // subordinate side
    output tcb_lite_pkg::tcb_req_t man_req [IFN-1:0],
    input  tcb_lite_pkg::tcb_rsp_t man_rsp [IFN-1:0]
);

    import tcb_lite_pkg::*;

    ////////////////////
    // local signals
    ////////////////////

    // handshake on the manager side
    logic           trn;
    // port that owns the pending response
    logic [IFL-1:0] rsp_sel;

    ////////////////////
    // control
    ////////////////////

    // transfer when selected port is ready
    assign trn = req.vld & rsp.rdy;

    // response select follows the request select at each transfer
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            rsp_sel <= '0;
        end else if (trn) begin
            rsp_sel <= sel;
        end
    end

    ////////////////////
    // request
    ////////////////////

    // copy to every port, only the selected one sees vld
    for (genvar i = 0; i < IFN; i++) begin: gen_req
        always_comb begin
            man_req[i]     = req;
            man_req[i].vld = (sel == IFL'(i)) ? req.vld : 1'b0;
        end
    end: gen_req

    ////////////////////
    // response
    ////////////////////

    // data and error from the port of the last transfer
    assign rsp.rdt = man_rsp[rsp_sel].rdt;
    assign rsp.err = man_rsp[rsp_sel].err;
    // ready from the port selected right now
    assign rsp.rdy = man_rsp[sel].rdy;

endmodule: tcb_lite_demultiplexer

// File: hdl/tcb_lite_memory.sv
// memory subordinate: word RAM, byte-enabled writes, registered read data
`timescale 1ns/1ps

module tcb_lite_memory #(
    // words in the array
    parameter int unsigned MEM_DEPTH = 256
)(
    // clock and reset
    input  logic                   sub,
    input  logic                   rst_n,
    // bus port
    input  tcb_lite_pkg::tcb_req_t req,
    output tcb_lite_pkg::tcb_rsp_t rsp
);

    import tcb_lite_pkg::*;

    ////////////////////
    // local signals
    ////////////////////

    // word index width
    localparam int unsigned AW = $clog2(MEM_DEPTH);

    // storage
    dat_t          mem [MEM_DEPTH];
    // word index, above the byte lanes
    logic [AW-1:0] idx;
    // handshake
    logic          trn;
    // read data register
    dat_t          rdt;

    assign idx = req.adr[AW+1:2];
    assign trn = req.vld & rsp.rdy;

    ////////////////////
    // write
    ////////////////////

    // only enabled lanes change
    always_ff @(posedge sub) begin
        if (trn && req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byt[b]) begin
                    mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    ////////////////////
    // read
    ////////////////////

    // zero on writes, stored word on reads
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            rdt <= '0;
        end else if (trn) begin
            rdt <= req.wen ? '0 : mem[idx];
        end
    end

    // always ready, never an error
    assign rsp.rdt = rdt;
    assign rsp.err = 1'b0;
    assign rsp.rdy = 1'b1;

endmodule: tcb_lite_memory

// File: hdl/tcb_lite_regs.sv
// register subordinate: scratch, identity, write count, error responses
`timescale 1ns/1ps
`include "tcb_lite_map.svh"

module tcb_lite_regs (
    // clock and reset
    input  logic                   sub,
    input  logic                   rst_n,
    // bus port
    input  tcb_lite_pkg::tcb_req_t req,
    output tcb_lite_pkg::tcb_rsp_t rsp
);

    import tcb_lite_pkg::*;

    ////////////////////
    // local signals
    ////////////////////

    // address checks
    logic in_win;
    adr_t ofs;
    // handshake
    logic trn;
    // decoded access
    logic acc_err;
    dat_t acc_rdt;
    // accepted error-free write
    logic wr_ok;
    // registers
    dat_t scratch;
    dat_t wcount;
    // response registers
    dat_t rdt;
    logic err;

    // inside the 16-byte window, word aligned offset
    assign in_win = (req.adr & ~(`MAP_REGS_SPAN - 32'd1)) == `MAP_REGS_BASE;
    assign ofs    = req.adr & (`MAP_REGS_SPAN - 32'd4);

    assign trn   = req.vld & rsp.rdy;
    assign wr_ok = trn & req.wen & ~acc_err;

    ////////////////////
    // access decode
    ////////////////////

    always_comb begin
        acc_err = 1'b0;
        acc_rdt = '0;
        if (!in_win) begin
            // unmapped, routed here by the decoder
            acc_err = 1'b1;
        end else begin
            case (ofs)
                REG_SCRATCH: acc_rdt = scratch;
                // read only, writes fail
                REG_ID: begin
                    acc_rdt = REG_ID_VALUE;
                    acc_err = req.wen;
                end
                REG_WCOUNT: begin
                    acc_rdt = wcount;
                    acc_err = req.wen;
                end
                // offset 12 is a hole
                default: acc_err = 1'b1;
            endcase
        end
    end

    ////////////////////
    // register update
    ////////////////////

    always_ff @(posedge sub) begin
        if (!rst_n) begin
            scratch <= '0;
            wcount  <= '0;
            rdt     <= '0;
            err     <= 1'b0;
        end else begin
            // scratch lanes by byte enable
            if (wr_ok && (ofs == REG_SCRATCH)) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.byt[b]) begin
                        scratch[8*b +: 8] <= req.wdt[8*b +: 8];
                    end
                end
            end
            if (wr_ok) begin
                wcount <= wcount + 32'd1;
            end
            // response, zero data on writes and errors
            if (trn) begin
                rdt <= (req.wen || acc_err) ? '0 : acc_rdt;
                err <= acc_err;
            end
        end
    end

    assign rsp.rdt = rdt;
    assign rsp.err = err;
    assign rsp.rdy = 1'b1;

endmodule: tcb_lite_regs

// File: hdl/tcb_lite_system.sv
// top level: decoder, demultiplexer, two memories and the register block
`timescale 1ns/1ps

module tcb_lite_system #(
    // subordinate ports on the demultiplexer
    parameter int unsigned IFN       = 3,
    // words per memory
    parameter int unsigned MEM_DEPTH = 256
)(
    // clock and reset
    input  logic                   sub,
    input  logic                   rst_n,
    // manager port
    input  tcb_lite_pkg::tcb_req_t req,
    output tcb_lite_pkg::tcb_rsp_t rsp
);

    import tcb_lite_pkg::*;

    ////////////////////
    // wires
    ////////////////////

    // decoded select
    logic [$clog2(IFN)-1:0] sel;
    // per-subordinate buses
    // 0 memory 0, 1 memory 1, 2 registers
    tcb_req_t man_req [IFN-1:0];
    tcb_rsp_t man_rsp [IFN-1:0];

    ////////////////////
    // interconnect
    ////////////////////

    tcb_lite_decoder u_decoder (
        .adr (req.adr),
        .sel (sel)
    );

    tcb_lite_demultiplexer #(
        .IFN (IFN)
    ) u_demultiplexer (
        .sub     (sub),
        .rst_n   (rst_n),
        .sel     (sel),
        .req     (req),
        .rsp     (rsp),
        .man_req (man_req),
        .man_rsp (man_rsp)
    );

    ////////////////////
    // subordinates
    ////////////////////

    tcb_lite_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem0 (
        .sub   (sub),
        .rst_n (rst_n),
        .req   (man_req[0]),
        .rsp   (man_rsp[0])
    );

    tcb_lite_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem1 (
        .sub   (sub),
        .rst_n (rst_n),
        .req   (man_req[1]),
        .rsp   (man_rsp[1])
    );

    tcb_lite_regs u_regs (
        .sub   (sub),
        .rst_n (rst_n),
        .req   (man_req[2]),
        .rsp   (man_rsp[2])
    );

endmodule: tcb_lite_system

// File: bench/tcb_lite_system_tb.sv
// testbench with clock, reset, stimulus table, table loop, response checks and summary
`timescale 1ns/1ps
`include "tcb_lite_map.svh"

module tcb_lite_system_tb;

    import tcb_lite_pkg::*;

    ////////////////////
    // constants
    ////////////////////

    // 20 ns clock
    localparam int HALF_PERIOD = 10;
    // inputs change this long after the rising edge
    localparam int DRIVE_DELAY = 2;
    // cycles allowed for rdy before giving up
    localparam int RDY_TIMEOUT = 16;

    // window bases from the address map
    localparam adr_t MEM0     = `MAP_MEM0_BASE;
    localparam adr_t MEM1     = `MAP_MEM1_BASE;
    localparam adr_t REGS     = `MAP_REGS_BASE;
    // outside every window so it lands on the register block
    localparam adr_t UNMAPPED = 32'h0000_2000;

    // table shorthands
    localparam logic RD  = 1'b0;
    localparam logic WR  = 1'b1;
    localparam logic OK  = 1'b0;
    localparam logic ERR = 1'b1;
    // GAP allows random idle cycles and B2B forbids them
    localparam logic GAP = 1'b0;
    localparam logic B2B = 1'b1;

    ////////////////////
    // table row
    ////////////////////

    typedef struct packed {
        logic chain;
        logic wen;
        adr_t adr;
        byt_t byt;
        dat_t wdt;
        dat_t exp_rdt;
        logic exp_err;
    } row_t;

    ////////////////////
    // signals
    ////////////////////

    logic     sub;
    logic     rst_n;
    tcb_req_t req;
    tcb_rsp_t rsp;

    // stimulus and expected responses
    row_t tbl [$];

    // bookkeeping
    int   errors;
    int   checks;
    logic timed_out;
    // row whose response is due in the current cycle
    logic pending;
    int   pending_row;

    ////////////////////
    // DUT
    ////////////////////

    tcb_lite_system #(
        .IFN       (3),
        .MEM_DEPTH (256)
    ) u_tcb_lite_system (
        .sub   (sub),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    // free running clock
    initial begin
        sub = 1'b0;
        forever #(HALF_PERIOD) sub = ~sub;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic row_t make_row(input logic chain, input logic wen, input adr_t adr,
                                      input byt_t byt, input dat_t wdt, input dat_t exp_rdt,
                                      input logic exp_err);
        row_t r;
        r.chain   = chain;
        r.wen     = wen;
        r.adr     = adr;
        r.byt     = byt;
        r.wdt     = wdt;
        r.exp_rdt = exp_rdt;
        r.exp_err = exp_err;
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR time %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        end
    endtask

    // previous transfer's response is valid in this cycle
    task automatic check_pending();
        if (pending) begin
            compare($sformatf("row %0d rdt", pending_row), tbl[pending_row].exp_rdt, rsp.rdt);
            compare($sformatf("row %0d err", pending_row), {31'b0, tbl[pending_row].exp_err},
                    {31'b0, rsp.err});
            pending = 1'b0;
        end
    endtask

    task automatic drive_row(input row_t r);
        req.vld = 1'b1;
        req.lck = 1'b0;
        req.wen = r.wen;
        req.adr = r.adr;
        // full word transfers only
        req.siz = 2'd2;
        req.byt = r.byt;
        req.wdt = r.wdt;
    endtask

    // one cycle with vld low
    task automatic idle_cycle();
        req = '0;
        @(negedge sub);
        check_pending();
        @(posedge sub);
        #(DRIVE_DELAY);
    endtask

    // rdy is sampled mid cycle and the transfer happens on the next edge
    task automatic wait_transfer(output logic ok);
        int cnt;
        cnt = 0;
        ok  = 1'b0;
        while (!ok && cnt < RDY_TIMEOUT) begin
            @(negedge sub);
            check_pending();
            if (rsp.rdy) begin
                ok = 1'b1;
            end
            @(posedge sub);
            #(DRIVE_DELAY);
            cnt++;
        end
    endtask

    ////////////////////
    // stimulus table
    ////////////////////

    task automatic fill_table();
        // same offset in both memories with different data
        tbl.push_back(make_row(GAP, WR, MEM0 + 32'h010, 4'hF, 32'h1111_2222, 32'h0, OK));
        tbl.push_back(make_row(GAP, WR, MEM1 + 32'h010, 4'hF, 32'hAAAA_BBBB, 32'h0, OK));
        tbl.push_back(make_row(GAP, RD, MEM0 + 32'h010, 4'hF, 32'h0, 32'h1111_2222, OK));
        tbl.push_back(make_row(GAP, RD, MEM1 + 32'h010, 4'hF, 32'h0, 32'hAAAA_BBBB, OK));
        // partial write to lanes 0 and 2 only
        tbl.push_back(make_row(GAP, WR, MEM1 + 32'h020, 4'hF, 32'h0102_0304, 32'h0, OK));
        tbl.push_back(make_row(GAP, WR, MEM1 + 32'h020, 4'h5, 32'hFFEE_DDCC, 32'h0, OK));
        tbl.push_back(make_row(GAP, RD, MEM1 + 32'h020, 4'hF, 32'h0, 32'h01EE_03CC, OK));
        // identity, count, scratch
        tbl.push_back(make_row(GAP, RD, REGS + REG_ID, 4'hF, 32'h0, REG_ID_VALUE, OK));
        tbl.push_back(make_row(GAP, RD, REGS + REG_WCOUNT, 4'hF, 32'h0, 32'd0, OK));
        tbl.push_back(make_row(GAP, WR, REGS + REG_SCRATCH, 4'hF, 32'hC0FF_EE00, 32'h0, OK));
        tbl.push_back(make_row(GAP, RD, REGS + REG_SCRATCH, 4'hF, 32'h0, 32'hC0FF_EE00, OK));
        // identity is read only and the failed write is not counted
        tbl.push_back(make_row(GAP, WR, REGS + REG_ID, 4'hF, 32'h0000_1234, 32'h0, ERR));
        tbl.push_back(make_row(GAP, RD, REGS + REG_WCOUNT, 4'hF, 32'h0, 32'd1, OK));
        // top lane of scratch only
        tbl.push_back(make_row(GAP, WR, REGS + REG_SCRATCH, 4'h8, 32'h5A00_0000, 32'h0, OK));
        tbl.push_back(make_row(GAP, RD, REGS + REG_SCRATCH, 4'hF, 32'h0, 32'h5AFF_EE00, OK));
        tbl.push_back(make_row(GAP, RD, REGS + REG_WCOUNT, 4'hF, 32'h0, 32'd2, OK));
        // count is read only too
        tbl.push_back(make_row(GAP, WR, REGS + REG_WCOUNT, 4'hF, 32'h0000_0055, 32'h0, ERR));
        // hole at offset 12
        tbl.push_back(make_row(GAP, RD, REGS + 32'h00C, 4'hF, 32'h0, 32'h0, ERR));
        // unmapped read and write followed by memory 0
        tbl.push_back(make_row(GAP, RD, UNMAPPED, 4'hF, 32'h0, 32'h0, ERR));
        tbl.push_back(make_row(GAP, WR, UNMAPPED, 4'hF, 32'hDEAD_BEEF, 32'h0, ERR));
        tbl.push_back(make_row(GAP, RD, MEM0 + 32'h010, 4'hF, 32'h0, 32'h1111_2222, OK));
        // back to back with memory 0 and registers interleaved
        tbl.push_back(make_row(GAP, WR, MEM0 + 32'h040, 4'hF, 32'h3333_4444, 32'h0, OK));
        tbl.push_back(make_row(B2B, RD, REGS + REG_SCRATCH, 4'hF, 32'h0, 32'h5AFF_EE00, OK));
        tbl.push_back(make_row(B2B, RD, MEM0 + 32'h040, 4'hF, 32'h0, 32'h3333_4444, OK));
        tbl.push_back(make_row(B2B, RD, REGS + REG_WCOUNT, 4'hF, 32'h0, 32'd2, OK));
        tbl.push_back(make_row(B2B, RD, MEM0 + 32'h010, 4'hF, 32'h0, 32'h1111_2222, OK));
        tbl.push_back(make_row(B2B, WR, REGS + REG_SCRATCH, 4'hF, 32'h0000_0077, 32'h0, OK));
        tbl.push_back(make_row(B2B, RD, REGS + REG_WCOUNT, 4'hF, 32'h0, 32'd3, OK));
        tbl.push_back(make_row(B2B, RD, MEM1 + 32'h010, 4'hF, 32'h0, 32'hAAAA_BBBB, OK));
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int unsigned gap;
        logic        ok;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        pending     = 1'b0;
        pending_row = 0;
        rst_n       = 1'b0;
        req         = '0;
        // fixed seed for the idle gaps
        void'($urandom(76));
        fill_table();

        // reset for 4 cycles
        repeat (4) @(posedge sub);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        for (int i = 0; i < tbl.size() && !timed_out; i++) begin
            // random idle unless chained
            gap = tbl[i].chain ? 32'd0 : $urandom_range(3, 0);
            repeat (gap) idle_cycle();
            drive_row(tbl[i]);
            wait_transfer(ok);
            if (ok) begin
                pending     = 1'b1;
                pending_row = i;
            end else begin
                timed_out = 1'b1;
                $display("rdy did not rise within %0d cycles for row %0d", RDY_TIMEOUT, i);
            end
        end

        // last response
        if (!timed_out) begin
            idle_cycle();
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule: tcb_lite_system_tb

// File: verilog.f
+incdir+include
hdl/tcb_lite_pkg.sv
hdl/tcb_lite_decoder.sv
hdl/tcb_lite_demultiplexer.sv
hdl/tcb_lite_memory.sv
hdl/tcb_lite_regs.sv
hdl/tcb_lite_system.sv
bench/tcb_lite_system_tb.sv

// File: Makefile
# Verilator lint and simulation for the bus subsystem

TOP = tcb_lite_system_tb

.PHONY: lint sim clean

# lint the RTL top level
lint:
	verilator --lint-only --timing -f verilog.f --top-module tcb_lite_system

# build and run, fail unless the pass line shows up
sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
